/* rtl/scalerPkg.sv */
`default_nettype none

package scalerPkg;

	localparam int PIX_W        = 8;
	localparam int X_RES_W      = 11;                        // Column index width
	localparam int Y_RES_W      = 11;                        // Row index width
	localparam int SCALE_INT_W  = 4;
	localparam int SCALE_FRAC_W = 14;
	localparam int SCALE_W      = SCALE_INT_W + SCALE_FRAC_W; // Q4.14 ratio
	localparam int FRAC_BITS    = 8;                         // Blend fraction bits
	localparam int COEFF_W      = FRAC_BITS + 1;             // Q1.8 coefficient
	localparam int FILL_W       = 3;                         // Holds LINE_BUFFERS+1
	localparam int CFG_DATA_W   = 18;

	typedef logic [PIX_W-1:0]   pixel_t;
	typedef logic [SCALE_W-1:0] ratio_t;
	typedef logic [COEFF_W-1:0] coeff_t;

	typedef enum logic {
		MODE_BILINEAR = 1'b0,
		MODE_NEAREST  = 1'b1
	} scaleMode_t;

	// Register map of the config port
	typedef enum logic [2:0] {
		REG_SRC_X   = 3'd0,
		REG_SRC_Y   = 3'd1,
		REG_DES_X   = 3'd2,
		REG_DES_Y   = 3'd3,
		REG_RATIO_X = 3'd4,
		REG_RATIO_Y = 3'd5,
		REG_MODE    = 3'd6
	} cfgAddr_t;

endpackage

`default_nettype wire

/* rtl/scalerIf.sv */
`default_nettype none

// Frame geometry and mode, all sizes stored as size minus 1
interface frameCfgIf;
	logic [scalerPkg::X_RES_W-1:0] srcX;
	logic [scalerPkg::Y_RES_W-1:0] srcY;
	logic [scalerPkg::X_RES_W-1:0] desX;
	logic [scalerPkg::Y_RES_W-1:0] desY;
	scalerPkg::ratio_t             ratioX; // Source step per output column
	scalerPkg::ratio_t             ratioY; // Source step per output line
	scalerPkg::scaleMode_t         mode;

	modport cfgSrc (output srcX, srcY, desX, desY, ratioX, ratioY, mode);
	modport cfgSink (input srcX, srcY, desX, desY, ratioX, ratioY, mode);
endinterface

// Line ring traffic between the two controllers and the RAMs
interface lineFifoIf;
	scalerPkg::pixel_t               wrData;
	logic [scalerPkg::X_RES_W-1:0]   wrAddr;
	logic                            wrEn;
	logic                            advanceWrite; // Kept line complete
	logic                            allWritten;   // Last source line stored
	logic [scalerPkg::X_RES_W-1:0]   rdAddr;
	logic                            advanceRead1;
	logic                            advanceRead2;
	logic [scalerPkg::FILL_W-1:0]    fillCount;
	scalerPkg::pixel_t               rd00, rd01, rd10, rd11; // Row then column

	modport writer (output wrData, wrAddr, wrEn, advanceWrite, allWritten, input fillCount);
	modport reader (output rdAddr, advanceRead1, advanceRead2,
		input fillCount, allWritten, rd00, rd01, rd10, rd11);
	modport ram (input wrData, wrAddr, wrEn, advanceWrite, rdAddr, advanceRead1, advanceRead2,
		output fillCount, rd00, rd01, rd10, rd11);
endinterface

`default_nettype wire

/* rtl/scalerCfgRegs.sv */
`default_nettype none

module scalerCfgRegs (
	input  wire logic                                clk,
	input  wire logic                                rst,
	input  wire logic                                i_cfgReq,
	input  wire scalerPkg::cfgAddr_t                 i_cfgAddr,
	input  wire logic [scalerPkg::CFG_DATA_W-1:0]    i_cfgData,
	output logic                                     o_cfgAck,
	frameCfgIf.cfgSrc                                cfg
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_cfgAck   <= 1'b0;
			cfg.srcX   <= '0;
			cfg.srcY   <= '0;
			cfg.desX   <= '0;
			cfg.desY   <= '0;
			cfg.ratioX <= '0;
			cfg.ratioY <= '0;
			cfg.mode   <= scalerPkg::MODE_BILINEAR;
		end else if (i_cfgReq && !o_cfgAck) begin // Rising phase, write once
			o_cfgAck <= 1'b1;
			case (i_cfgAddr)
				scalerPkg::REG_SRC_X:   cfg.srcX   <= i_cfgData[scalerPkg::X_RES_W-1:0];
				scalerPkg::REG_SRC_Y:   cfg.srcY   <= i_cfgData[scalerPkg::Y_RES_W-1:0];
				scalerPkg::REG_DES_X:   cfg.desX   <= i_cfgData[scalerPkg::X_RES_W-1:0];
				scalerPkg::REG_DES_Y:   cfg.desY   <= i_cfgData[scalerPkg::Y_RES_W-1:0];
				scalerPkg::REG_RATIO_X: cfg.ratioX <= i_cfgData[scalerPkg::SCALE_W-1:0];
				scalerPkg::REG_RATIO_Y: cfg.ratioY <= i_cfgData[scalerPkg::SCALE_W-1:0];
				scalerPkg::REG_MODE:    cfg.mode   <= scalerPkg::scaleMode_t'(i_cfgData[0]);
				default: ;                                   // Unmapped address ignored
			endcase
		end else if (!i_cfgReq) begin
			o_cfgAck <= 1'b0;                                // Falling phase
		end
	end

endmodule

`default_nettype wire

/* rtl/lineRamFifo.sv */
`default_nettype none

module lineRamFifo #(
	parameter int LINE_BUFFERS = 4
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic i_frameStart,
	lineFifoIf.ram    ring
);

	localparam int PTR_W = $clog2(LINE_BUFFERS);

	scalerPkg::pixel_t             lineMem [LINE_BUFFERS][1 << scalerPkg::X_RES_W];
	logic [PTR_W-1:0]              wrLine;    // Line being filled
	logic [PTR_W-1:0]              rdLine;    // Top line of the blend window
	logic [PTR_W-1:0]              botLine;
	logic [scalerPkg::X_RES_W-1:0] lastCol;   // Last column of a stored line
	logic [scalerPkg::X_RES_W-1:0] rightCol;
	logic [scalerPkg::FILL_W-1:0]  readDrop;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(LINE_BUFFERS - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Right and bottom edges repeat the last pixel and line
	assign rightCol = (ring.rdAddr >= lastCol) ? ring.rdAddr : ring.rdAddr + 1'b1;
	assign botLine  = (ring.fillCount > scalerPkg::FILL_W'(1)) ? nextPtr(rdLine) : rdLine;

	always_comb begin
		if (ring.advanceRead2)
			readDrop = scalerPkg::FILL_W'(2);
		else if (ring.advanceRead1)
			readDrop = scalerPkg::FILL_W'(1);
		else
			readDrop = '0;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wrLine         <= '0;
			rdLine         <= '0;
			lastCol        <= '0;
			ring.fillCount <= '0;
		end else if (i_frameStart) begin     // New frame empties the ring
			wrLine         <= '0;
			rdLine         <= '0;
			lastCol        <= '0;
			ring.fillCount <= '0;
		end else begin
			if (ring.advanceWrite) begin
				wrLine  <= nextPtr(wrLine);
				lastCol <= ring.wrAddr;      // Coincides with the final pixel write
			end
			if (ring.advanceRead2)
				rdLine <= nextPtr(nextPtr(rdLine));
			else if (ring.advanceRead1)
				rdLine <= nextPtr(rdLine);
			ring.fillCount <= ring.fillCount + scalerPkg::FILL_W'(ring.advanceWrite) - readDrop;
		end
	end

	// Line RAMs, one-cycle registered read of the 2x2 window
	always_ff @(posedge clk) begin
		if (ring.wrEn)
			lineMem[wrLine][ring.wrAddr] <= ring.wrData;
		ring.rd00 <= lineMem[rdLine][ring.rdAddr];
		ring.rd01 <= lineMem[rdLine][rightCol];
		ring.rd10 <= lineMem[botLine][ring.rdAddr];
		ring.rd11 <= lineMem[botLine][rightCol];
	end

endmodule

`default_nettype wire

/* rtl/scalerWriteCtrl.sv */
`default_nettype none

module scalerWriteCtrl #(
	parameter int LINE_BUFFERS = 4
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              i_frameStart,
	input  wire scalerPkg::pixel_t i_vidData,
	input  wire logic              i_vidDe,
	output logic                   o_vidReady,
	frameCfgIf.cfgSink             cfg,
	lineFifoIf.writer              ring
);

	localparam int BASE_W = scalerPkg::Y_RES_W + scalerPkg::SCALE_INT_W;
	localparam int PROD_W = scalerPkg::Y_RES_W + scalerPkg::SCALE_W;

	logic                          accepting;   // Frame in progress
	logic                          frameIn;     // Last source line accepted
	logic                          keepLine;    // Current line goes to the ring
	logic [scalerPkg::X_RES_W-1:0] colCount;
	logic [scalerPkg::Y_RES_W-1:0] rowCount;
	logic [scalerPkg::Y_RES_W-1:0] needLine;    // Output line being tracked
	logic [PROD_W-1:0]             needProduct;
	logic [BASE_W-1:0]             needBase;    // Its top source row
	logic [BASE_W-1:0]             nextRow;
	logic                          accept;
	logic                          lineEnd;
	logic                          catchUp;
	logic                          keepNext;

	assign needProduct = needLine * cfg.ratioY;
	assign needBase    = needProduct[PROD_W-1:scalerPkg::SCALE_FRAC_W];
	assign nextRow     = BASE_W'(rowCount) + BASE_W'(1);

	// Move on while the tracked output line no longer touches nextRow
	assign catchUp  = ((needBase + BASE_W'(1)) < nextRow) && (needLine != cfg.desY);
	assign keepNext = ((needBase + BASE_W'(1)) >= nextRow) && (needBase <= nextRow);

	// Hold off while the ring is full, counting a pending advance
	assign o_vidReady = accepting &&
		((ring.fillCount + scalerPkg::FILL_W'(ring.advanceWrite)) <
		scalerPkg::FILL_W'(LINE_BUFFERS));
	assign accept  = i_vidDe && o_vidReady;
	assign lineEnd = accept && (colCount == cfg.srcX);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			accepting         <= 1'b0;
			frameIn           <= 1'b0;
			keepLine          <= 1'b0;
			colCount          <= '0;
			rowCount          <= '0;
			needLine          <= '0;
			ring.wrEn         <= 1'b0;
			ring.advanceWrite <= 1'b0;
			ring.allWritten   <= 1'b0;
		end else if (i_frameStart) begin
			accepting         <= 1'b1;
			frameIn           <= 1'b0;
			keepLine          <= 1'b1;     // Row 0 is always needed
			colCount          <= '0;
			rowCount          <= '0;
			needLine          <= '0;
			ring.wrEn         <= 1'b0;
			ring.advanceWrite <= 1'b0;
			ring.allWritten   <= 1'b0;
		end else begin
			ring.wrEn         <= accept && keepLine;
			ring.advanceWrite <= lineEnd && keepLine;
			ring.allWritten   <= frameIn;  // Lands with the last fill update
			if (catchUp)
				needLine <= needLine + 1'b1;
			if (lineEnd) begin
				colCount <= '0;
				rowCount <= rowCount + 1'b1;
				keepLine <= keepNext;      // Skipped lines are read and dropped
				if (rowCount == cfg.srcY) begin
					accepting <= 1'b0;
					frameIn   <= 1'b1;
				end
			end else if (accept) begin
				colCount <= colCount + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		ring.wrData <= i_vidData;
		ring.wrAddr <= colCount;
	end

endmodule

`default_nettype wire

/* rtl/scalerReadCtrl.sv */
`default_nettype none

module scalerReadCtrl (
	input  wire logic         clk,
	input  wire logic         rst,
	input  wire logic         i_frameStart,
	input  wire logic         i_voutRead,
	frameCfgIf.cfgSink        cfg,
	lineFifoIf.reader         ring,
	output logic              o_rdStrobe,
	output scalerPkg::coeff_t o_xBlend,
	output scalerPkg::coeff_t o_yBlend
);

	localparam int X_AMT_W = scalerPkg::X_RES_W + scalerPkg::SCALE_FRAC_W;
	localparam int Y_AMT_W = scalerPkg::Y_RES_W + scalerPkg::SCALE_FRAC_W;
	localparam int FRAC_LO = scalerPkg::SCALE_FRAC_W - scalerPkg::FRAC_BITS;

	logic                          running;   // Ring holds enough lines
	logic                          pause;     // Line switch bubble
	logic                          frameOut;  // All output pixels started
	logic [scalerPkg::X_RES_W-1:0] outCol;
	logic [scalerPkg::Y_RES_W-1:0] outLine;
	logic [X_AMT_W-1:0]            xAmt;      // Source column, Q11.14
	logic [Y_AMT_W-1:0]            yAmt;      // Source row, Q11.14
	logic [Y_AMT_W-1:0]            yAmtNext;  // Row of the following output line
	logic [scalerPkg::Y_RES_W-1:0] yInt;
	logic [scalerPkg::Y_RES_W-1:0] yIntNext;
	logic                          start;

	assign yInt        = yAmt[Y_AMT_W-1:scalerPkg::SCALE_FRAC_W];
	assign yIntNext    = yAmtNext[Y_AMT_W-1:scalerPkg::SCALE_FRAC_W];
	assign ring.rdAddr = xAmt[X_AMT_W-1:scalerPkg::SCALE_FRAC_W];
	assign start       = i_voutRead && running && !pause;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			running           <= 1'b0;
			pause             <= 1'b0;
			frameOut          <= 1'b0;
			outCol            <= '0;
			outLine           <= '0;
			xAmt              <= '0;
			yAmt              <= '0;
			yAmtNext          <= '0;
			ring.advanceRead1 <= 1'b0;
			ring.advanceRead2 <= 1'b0;
			o_rdStrobe        <= 1'b0;
		end else if (i_frameStart) begin
			running           <= 1'b0;
			pause             <= 1'b0;
			frameOut          <= 1'b0;
			outCol            <= '0;
			outLine           <= '0;
			xAmt              <= '0;
			yAmt              <= '0;
			yAmtNext          <= Y_AMT_W'(cfg.ratioY);
			ring.advanceRead1 <= 1'b0;
			ring.advanceRead2 <= 1'b0;
			o_rdStrobe        <= 1'b0;
		end else begin
			ring.advanceRead1 <= 1'b0;        // Single-cycle pulses
			ring.advanceRead2 <= 1'b0;
			pause             <= 1'b0;
			o_rdStrobe        <= start;
			if (start) begin
				if (outCol == cfg.desX) begin
					outCol <= '0;
					xAmt   <= '0;
					pause  <= 1'b1;           // Lets the new top line reach the RAM read
					if (outLine == cfg.desY) begin
						running  <= 1'b0;
						frameOut <= 1'b1;
					end else begin
						outLine  <= outLine + 1'b1;
						yAmt     <= yAmtNext;
						yAmtNext <= yAmtNext + Y_AMT_W'(cfg.ratioY);
						if (yIntNext == yInt + 1'b1) begin
							ring.advanceRead1 <= 1'b1;
							if (ring.fillCount < scalerPkg::FILL_W'(3) && !ring.allWritten)
								running <= 1'b0;
						end else if (yIntNext > yInt + 1'b1) begin
							ring.advanceRead2 <= 1'b1;
							if (ring.fillCount < scalerPkg::FILL_W'(4) && !ring.allWritten)
								running <= 1'b0;
						end
					end
				end else begin
					outCol <= outCol + 1'b1;
					xAmt   <= xAmt + X_AMT_W'(cfg.ratioX);
				end
			end else if (!running && !frameOut && !ring.advanceRead1 && !ring.advanceRead2 &&
				(ring.fillCount >= scalerPkg::FILL_W'(2) || ring.allWritten)) begin
				running <= 1'b1;                   // Two lines stored or input finished
			end
		end
	end

	// Blend fractions travel with the strobe
	always_ff @(posedge clk) begin
		o_xBlend <= {1'b0, xAmt[scalerPkg::SCALE_FRAC_W-1:FRAC_LO]};
		o_yBlend <= {1'b0, yAmt[scalerPkg::SCALE_FRAC_W-1:FRAC_LO]};
	end

endmodule

`default_nettype wire

/* rtl/blendPipe.sv */
`default_nettype none

module blendPipe (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              i_rdStrobe,
	input  wire scalerPkg::coeff_t i_xBlend,
	input  wire scalerPkg::coeff_t i_yBlend,
	lineFifoIf.reader              ring,
	frameCfgIf.cfgSink             cfg,
	output scalerPkg::pixel_t      o_voutData,
	output logic                   o_voutDe
);

	localparam int                COEFF_W = scalerPkg::COEFF_W;
	localparam int                PROD_W  = scalerPkg::PIX_W + COEFF_W;
	localparam scalerPkg::coeff_t ONE     = COEFF_W'(1 << scalerPkg::FRAC_BITS);
	localparam scalerPkg::coeff_t HALF    = COEFF_W'(1 << (scalerPkg::FRAC_BITS - 1));

	scalerPkg::coeff_t wx [2];          // Horizontal weights, left then right
	scalerPkg::coeff_t wy [2];          // Vertical weights, top then bottom
	scalerPkg::coeff_t coeffNext [4];   // Index is 2*row + col
	scalerPkg::coeff_t coeff [4];
	scalerPkg::pixel_t pix [4];
	logic [PROD_W-1:0] prod [4];
	logic [PROD_W+1:0] sum;
	logic              xHigh;
	logic              yHigh;
	logic              de1, de2;

	// Weight product rounded to Q1.8
	function automatic scalerPkg::coeff_t weight(input scalerPkg::coeff_t a,
		input scalerPkg::coeff_t b);
		logic [2*COEFF_W-1:0] full;
		full = a * b;
		full = full + (2*COEFF_W)'(HALF - 1'b1);
		return COEFF_W'(full >> scalerPkg::FRAC_BITS);
	endfunction

	assign xHigh = i_xBlend >= HALF;
	assign yHigh = i_yBlend >= HALF;

	always_comb begin
		wx[0] = ONE - i_xBlend;
		wx[1] = i_xBlend;
		wy[0] = ONE - i_yBlend;
		wy[1] = i_yBlend;
		for (int y = 0; y < 2; y++) begin
			for (int x = 0; x < 2; x++) begin
				if (cfg.mode == scalerPkg::MODE_BILINEAR)
					coeffNext[2*y + x] = weight(wx[x], wy[y]);
				else                                    // Nearest picks one neighbor
					coeffNext[2*y + x] = (xHigh == (x != 0) && yHigh == (y != 0)) ? ONE : '0;
			end
		end
	end

	always_comb begin
		sum = '0;
		for (int i = 0; i < 4; i++)
			sum = sum + (PROD_W + 2)'(prod[i]);
	end

	// Stage 1 registers, stage 2 multiply, stage 3 sum
	always_ff @(posedge clk) begin
		pix[0] <= ring.rd00;
		pix[1] <= ring.rd01;
		pix[2] <= ring.rd10;
		pix[3] <= ring.rd11;
		for (int i = 0; i < 4; i++) begin
			coeff[i] <= coeffNext[i];
			prod[i]  <= pix[i] * coeff[i];
		end
		o_voutData <= scalerPkg::pixel_t'(sum >> scalerPkg::FRAC_BITS);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			de1      <= 1'b0;
			de2      <= 1'b0;
			o_voutDe <= 1'b0;
		end else begin
			de1      <= i_rdStrobe;   // Enable follows the data stages
			de2      <= de1;
			o_voutDe <= de2;
		end
	end

endmodule

`default_nettype wire

/* rtl/videoScaler.sv */
`default_nettype none

module videoScaler #(
	parameter int LINE_BUFFERS = 4
) (
	input  wire logic                             clk,
	input  wire logic                             rst,
	input  wire logic                             i_cfgReq,
	input  wire scalerPkg::cfgAddr_t              i_cfgAddr,
	input  wire logic [scalerPkg::CFG_DATA_W-1:0] i_cfgData,
	output logic                                  o_cfgAck,
	input  wire logic                             i_vidVs,   // Frame start pulse
	input  wire scalerPkg::pixel_t                i_vidData,
	input  wire logic                             i_vidDe,
	output logic                                  o_vidReady,
	input  wire logic                             i_voutRead,
	output scalerPkg::pixel_t                     o_voutData,
	output logic                                  o_voutDe
);

	frameCfgIf cfgBus ();
	lineFifoIf ringBus ();

	logic              rdStrobe;
	scalerPkg::coeff_t xBlend;
	scalerPkg::coeff_t yBlend;

	scalerCfgRegs cfgRegs_i (
		.clk, .rst, .i_cfgReq, .i_cfgAddr, .i_cfgData, .o_cfgAck,
		.cfg (cfgBus.cfgSrc)
	);

	lineRamFifo #(.LINE_BUFFERS(LINE_BUFFERS)) ringRam_i (
		.clk, .rst, .i_frameStart(i_vidVs), .ring(ringBus.ram)
	);

	scalerWriteCtrl #(.LINE_BUFFERS(LINE_BUFFERS)) writeCtrl_i (
		.clk, .rst, .i_frameStart(i_vidVs), .i_vidData, .i_vidDe, .o_vidReady,
		.cfg (cfgBus.cfgSink), .ring(ringBus.writer)
	);

	scalerReadCtrl readCtrl_i (
		.clk, .rst, .i_frameStart(i_vidVs), .i_voutRead,
		.cfg (cfgBus.cfgSink), .ring(ringBus.reader),
		.o_rdStrobe(rdStrobe), .o_xBlend(xBlend), .o_yBlend(yBlend)
	);

	blendPipe blend_i (
		.clk, .rst, .i_rdStrobe(rdStrobe), .i_xBlend(xBlend), .i_yBlend(yBlend),
		.ring(ringBus.reader), .cfg(cfgBus.cfgSink), .o_voutData, .o_voutDe
	);

endmodule

`default_nettype wire

/* verif/videoScalerTb.sv */
`default_nettype none

module videoScalerTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int    MAX_TESTS    = 8;
	localparam string PATTERN_FILE = "verif/scalerPatterns.txt";

	logic                             clk = 1'b0;
	logic                             rst;
	logic                             i_cfgReq;
	scalerPkg::cfgAddr_t              i_cfgAddr;
	logic [scalerPkg::CFG_DATA_W-1:0] i_cfgData;
	logic                             o_cfgAck;
	logic                             i_vidVs;
	scalerPkg::pixel_t                i_vidData;
	logic                             i_vidDe;
	logic                             o_vidReady;
	logic                             i_voutRead;
	scalerPkg::pixel_t                o_voutData;
	logic                             o_voutDe;

	string             tName [MAX_TESTS];
	logic              tStall [MAX_TESTS];              // Random read gaps
	int unsigned       cfgVal [MAX_TESTS][7];           // In register address order
	int                inBase [MAX_TESTS];
	int                outBase [MAX_TESTS];
	scalerPkg::pixel_t inPix [$];
	scalerPkg::pixel_t outPix [$];
	int                numTests = 0;
	int                valueErrors = 0;
	int                otherErrors = 0;
	int                cycles = 0;
	int                cycleLimit = 2000;               // Grows with the loaded tests
	string             curName = "none";
	int                curOutBase = 0;
	int                curOutCount = 0;
	int                gotCount = 0;
	logic              frameStarted = 1'b0;
	logic              stallReads = 1'b0;
	logic [31:0]       rng = 32'd76647;

	videoScaler #(.LINE_BUFFERS(4)) videoScaler_i (
		.clk, .rst, .i_cfgReq, .i_cfgAddr, .i_cfgData, .o_cfgAck,
		.i_vidVs, .i_vidData, .i_vidDe, .o_vidReady,
		.i_voutRead, .o_voutData, .o_voutDe
	);

	always #5 clk = ~clk;                               // 10 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Error summary, then the verdict
	task automatic reportAndFinish();
		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	// Sink readiness, roughly 60 percent when gaps are on
	always @(posedge clk) begin
		if (stallReads) begin
			rng = xorshift(rng);
			i_voutRead <= (rng[7:0] > 8'd100);
		end else begin
			i_voutRead <= 1'b1;
		end
	end

	// Output pixels checked in arrival order
	always @(posedge clk) begin
		if (o_voutDe) begin
			assert (frameStarted) else begin
				otherErrors++;
				$display("Output valid seen before the first frame was started");
			end
			if (frameStarted) begin
				assert (gotCount < curOutCount) else begin
					otherErrors++;
					$display("Extra output pixel %0d in test %s", gotCount, curName);
				end
				if (gotCount < curOutCount) begin
					assert (o_voutData == outPix[curOutBase + gotCount]) else begin
						valueErrors++;
						$display("error %s pixel %0d expected %02h actual %02h", curName,
							gotCount, outPix[curOutBase + gotCount], o_voutData);
					end
				end
			end
			gotCount++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			otherErrors++;
			$display("Timeout after %0d cycles in test %s", cycles, curName);
			reportAndFinish();
		end
	end

	task automatic loadPatterns(input int fd);
		string       line;
		string       name;
		int          stall;
		int          code;
		int          nIn;
		int          nOut;
		int unsigned v [7];
		int unsigned pix;
		while (!$feof(fd) && numTests < MAX_TESTS) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n")
				continue;                                   // Comment or blank line
			code = $sscanf(line, "%s %d %d %d %d %d %h %h %d", name, stall,
				v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
			if (code != 9) begin
				otherErrors++;
				$display("Malformed test header in pattern file: %s", line);
				continue;
			end
			tName[numTests]   = name;
			tStall[numTests]  = (stall != 0);
			cfgVal[numTests]  = v;
			inBase[numTests]  = inPix.size();
			outBase[numTests] = outPix.size();
			nIn  = (v[0] + 1) * (v[1] + 1);
			nOut = (v[2] + 1) * (v[3] + 1);
			for (int i = 0; i < nIn + nOut; i++) begin
				code = $fscanf(fd, "%h", pix);
				if (code != 1) begin
					otherErrors++;
					$display("Pattern file ends early in test %s", name);
					return;
				end
				if (i < nIn)
					inPix.push_back(scalerPkg::pixel_t'(pix));
				else
					outPix.push_back(scalerPkg::pixel_t'(pix));
			end
			cycleLimit += 40 * (nIn + nOut);
			numTests++;
		end
	endtask

	// Four-phase write, ack must rise then fall within 20 cycles each
	task automatic writeReg(input scalerPkg::cfgAddr_t addr,
		input logic [scalerPkg::CFG_DATA_W-1:0] data);
		int n;
		i_cfgAddr <= addr;
		i_cfgData <= data;
		i_cfgReq  <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!o_cfgAck && n < 20);
		assert (o_cfgAck) else begin
			otherErrors++;
			$display("Config ack did not rise within 20 cycles for register %0d", addr);
		end
		i_cfgReq <= 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (o_cfgAck && n < 20);
		assert (!o_cfgAck) else begin
			otherErrors++;
			$display("Config ack did not fall within 20 cycles for register %0d", addr);
		end
	endtask

	task automatic runTest(input int t);
		int idx;
		int nIn;
		int nOut;
		nIn  = (cfgVal[t][0] + 1) * (cfgVal[t][1] + 1);
		nOut = (cfgVal[t][2] + 1) * (cfgVal[t][3] + 1);
		for (int k = 0; k < 7; k++)
			writeReg(scalerPkg::cfgAddr_t'(k), cfgVal[t][k][scalerPkg::CFG_DATA_W-1:0]);
		curName     = tName[t];
		curOutBase  = outBase[t];
		curOutCount = nOut;
		gotCount    = 0;                                // No pixel in flight between frames
		stallReads  = tStall[t];
		i_vidVs     <= 1'b1;
		frameStarted = 1'b1;
		@(posedge clk);
		i_vidVs   <= 1'b0;
		i_vidDe   <= 1'b1;
		i_vidData <= inPix[inBase[t]];
		idx = 0;
		while (idx < nIn) begin
			@(posedge clk);
			if (o_vidReady) begin                       // Pixel taken on this edge
				idx++;
				if (idx < nIn)
					i_vidData <= inPix[inBase[t] + idx];
				else
					i_vidDe <= 1'b0;
			end
		end
		@(posedge clk);                                 // Ready drops after the last pixel
		assert (!o_vidReady) else begin
			otherErrors++;
			$display("Input ready still high after the whole frame of test %s was accepted",
				curName);
		end
		while (gotCount < nOut)
			@(posedge clk);
		repeat (20) @(posedge clk);                     // Quiet window for stray pixels
		assert (gotCount == nOut) else begin
			valueErrors++;
			$display("error %s pixel count expected %0d actual %0d", curName, nOut, gotCount);
		end
		stallReads = 1'b0;
	endtask

	initial begin
		int fd;
		rst        <= 1'b1;
		i_cfgReq   <= 1'b0;
		i_cfgAddr  <= scalerPkg::REG_SRC_X;
		i_cfgData  <= '0;
		i_vidVs    <= 1'b0;
		i_vidData  <= '0;
		i_vidDe    <= 1'b0;
		i_voutRead <= 1'b0;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			otherErrors++;
			$display("Cannot open pattern file %s", PATTERN_FILE);
		end else begin
			loadPatterns(fd);
			$fclose(fd);
			if (numTests == 0) begin
				otherErrors++;
				$display("Pattern file holds no test records");
			end
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk);
		assert (!o_vidReady && !o_cfgAck) else begin
			otherErrors++;
			$display("Input ready or config ack high after reset with no frame or request");
		end
		for (int t = 0; t < numTests; t++)
			runTest(t);
		reportAndFinish();
	end

endmodule

`default_nettype wire

/* verif/scalerPatterns.txt */
# name stall srcX srcY desX desY ratioX ratioY mode (sizes minus 1, ratios hex Q4.14)
# then source pixels and expected output pixels in hex, row by row, mode 1 is nearest
identity 0 3 3 3 3 4000 4000 0
12 34 56 78 9a bc de f0 0f 1e 2d 3c 4b 5a 69 87
12 34 56 78 9a bc de f0 0f 1e 2d 3c 4b 5a 69 87

nearestDown 0 7 7 3 3 8000 8000 1
00 01 02 03 04 05 06 07 10 11 12 13 14 15 16 17 20 21 22 23 24 25 26 27 30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47 50 51 52 53 54 55 56 57 60 61 62 63 64 65 66 67 70 71 72 73 74 75 76 77
00 02 04 06 20 22 24 26 40 42 44 46 60 62 64 66

bilinearUp 0 1 1 3 3 2000 2000 0
0a 32 5a c8
0a 1e 32 32 32 57 7d 7d 5a 91 c8 c8 5a 91 c8 c8

bilinearUpStall 1 1 1 3 3 2000 2000 0
0a 32 5a c8
0a 1e 32 32 32 57 7d 7d 5a 91 c8 c8 5a 91 c8 c8

/* videoScaler.f */
rtl/scalerPkg.sv
rtl/scalerIf.sv
rtl/scalerCfgRegs.sv
rtl/lineRamFifo.sv
rtl/scalerWriteCtrl.sv
rtl/scalerReadCtrl.sv
rtl/blendPipe.sv
rtl/videoScaler.sv
verif/videoScalerTb.sv

/* Bender.yml */
package:
  name: videoScaler

sources:
  - rtl/scalerPkg.sv
  - rtl/scalerIf.sv
  - rtl/scalerCfgRegs.sv
  - rtl/lineRamFifo.sv
  - rtl/scalerWriteCtrl.sv
  - rtl/scalerReadCtrl.sv
  - rtl/blendPipe.sv
  - rtl/videoScaler.sv
  - target: test
    files:
      - verif/videoScalerTb.sv
